// ==== rtl/mipsConsts.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips core constants
// word sizes, instruction fields and select codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath geometry
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// opcodes of the supported subset
`define OP_RTYPE 6'b000000
`define OP_ADDI 6'b001000
`define OP_LW 6'b100011
`define OP_SW 6'b101011
`define OP_BEQ 6'b000100
`define OP_J 6'b000010

// r-type function codes
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR 6'b100101
`define FN_SLT 6'b101010

// alu operation codes, bit 2 inverts operand b
`define ALU_AND 3'b000
`define ALU_OR 3'b001
`define ALU_ADD 3'b010
`define ALU_SUB 3'b110
`define ALU_SLT 3'b111

// execute operand bypass selects
`define FWD_NONE 2'b00
`define FWD_WB 2'b01
`define FWD_MEM 2'b10

// next pc selects
`define PC_SEQ 2'b00
`define PC_BRANCH 2'b01
`define PC_JUMP 2'b10

`endif

// ==== rtl/mipsPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips core types
// instruction views, control bundle, stage registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mipsConsts.svh"

package mipsPkg;

	// register form, rd/shamt/funct live in the low half
	typedef struct packed {
		logic [5:0] opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormT;

	// immediate form, same rs/rt, imm overlays rd/shamt/funct
	typedef struct packed {
		logic [5:0] opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [15:0] imm;
	} iFormT;

	// jump form, 26 bit word target
	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target;
	} jFormT;

	// one fetched word, decoded per opcode
	typedef union packed {
		rFormT rForm;
		iFormT iForm;
		jFormT jForm;
	} instrWord;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic [2:0] aluControl;
		logic branch;
		logic jump;
	} ctrlBundle;

	typedef struct packed {
		ctrlBundle ctrl;
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] b;
		logic [`DATA_WIDTH-1:0] signImm;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
	} decExReg;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic [`DATA_WIDTH-1:0] aluOut;
		logic [`DATA_WIDTH-1:0] writeData;
		logic [`REG_ADDR_WIDTH-1:0] writeReg;
	} exMemReg;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [`DATA_WIDTH-1:0] readData;
		logic [`DATA_WIDTH-1:0] aluOut;
		logic [`REG_ADDR_WIDTH-1:0] writeReg;
	} memWbReg;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] writeData;
		logic write;
	} dmemRequest;

endpackage

// ==== rtl/fetchStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage
// pc, next address mux and fetch/decode register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsConsts.svh"

module fetchStage import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic stallF,
	input logic stallD,
	input logic flushD,
	input logic [1:0] pcSel,
	input logic [`DATA_WIDTH-1:0] branchTarget,
	input logic [`DATA_WIDTH-1:0] jumpTarget,
	input logic [`DATA_WIDTH-1:0] imemInstr,
	output logic [`DATA_WIDTH-1:0] imemAddr,
	output instrWord instrD,
	output logic [`DATA_WIDTH-1:0] pcPlus4D
);

	logic [`DATA_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] pcPlus4F;
	logic [`DATA_WIDTH-1:0] nextPc;

	// imem answers in this same cycle
	assign imemAddr = pc;
	assign pcPlus4F = pc + `DATA_WIDTH'd4;

	// targets come back from decode
	always_comb begin
		case (pcSel)
			`PC_BRANCH: nextPc = branchTarget;
			`PC_JUMP: nextPc = jumpTarget;
			default: nextPc = pcPlus4F;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (!stallF) begin
			pc <= nextPc;
		end
	end

	// all zero word decodes as a nop
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrD <= '0;
			pcPlus4D <= '0;
		end else if (!stallD) begin
			if (flushD) begin
				// drop the word fetched behind a taken branch or jump
				instrD <= '0;
				pcPlus4D <= '0;
			end else begin
				instrD <= imemInstr;
				pcPlus4D <= pcPlus4F;
			end
		end
	end

endmodule

// ==== rtl/decodeStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage
// register file, branch compare and decode/execute register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsConsts.svh"

module decodeStage import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input instrWord instrD,
	input logic [`DATA_WIDTH-1:0] pcPlus4D,
	input ctrlBundle ctrlD,
	input logic flushE,
	input logic forwardAD,
	input logic forwardBD,
	input logic [`DATA_WIDTH-1:0] aluOutM,
	input logic wbRegWrite,
	input logic [`REG_ADDR_WIDTH-1:0] wbWriteReg,
	input logic [`DATA_WIDTH-1:0] wbResult,
	output logic equalD,
	output logic [`DATA_WIDTH-1:0] branchTarget,
	output logic [`DATA_WIDTH-1:0] jumpTarget,
	output decExReg decEx
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
	logic [`DATA_WIDTH-1:0] regA;
	logic [`DATA_WIDTH-1:0] regB;
	logic [`DATA_WIDTH-1:0] cmpA;
	logic [`DATA_WIDTH-1:0] cmpB;
	logic [`DATA_WIDTH-1:0] signImm;
	logic [`REG_ADDR_WIDTH-1:0] rsD;
	logic [`REG_ADDR_WIDTH-1:0] rtD;

	assign rsD = instrD.rForm.rs;
	assign rtD = instrD.rForm.rt;

	// writes land on the falling edge
	// so a read in the second half of the cycle sees them
	always_ff @(negedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbRegWrite) begin
			regs[wbWriteReg] <= wbResult;
		end
	end

	// r0 always reads zero
	assign regA = (rsD == '0) ? '0 : regs[rsD];
	assign regB = (rtD == '0) ? '0 : regs[rtD];

	// branch compare takes the memory stage result early
	assign cmpA = forwardAD ? aluOutM : regA;
	assign cmpB = forwardBD ? aluOutM : regB;
	assign equalD = (cmpA == cmpB);

	assign signImm = {{16{instrD.iForm.imm[15]}}, instrD.iForm.imm};
	// word offset relative to the next pc
	assign branchTarget = pcPlus4D + (signImm << 2);
	// upper pc bits kept from the delay-free next pc
	assign jumpTarget = {pcPlus4D[`DATA_WIDTH-1:28], instrD.jForm.target, 2'b00};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decEx <= '0;
		end else if (flushE) begin
			// bubble, all control low
			decEx <= '0;
		end else begin
			decEx.ctrl <= ctrlD;
			decEx.a <= regA;
			decEx.b <= regB;
			decEx.signImm <= signImm;
			decEx.rs <= rsD;
			decEx.rt <= rtD;
			decEx.rd <= instrD.rForm.rd;
		end
	end

endmodule

// ==== rtl/executeStage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage
// operand bypass, alu and execute/memory register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsConsts.svh"

module executeStage import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input decExReg decEx,
	input logic [1:0] forwardAE,
	input logic [1:0] forwardBE,
	input logic [`DATA_WIDTH-1:0] aluOutM,
	input logic [`DATA_WIDTH-1:0] wbResult,
	output exMemReg exMem,
	output logic [`REG_ADDR_WIDTH-1:0] writeRegE,
	output logic regWriteE,
	output logic memToRegE
);

	logic [`DATA_WIDTH-1:0] srcA;
	logic [`DATA_WIDTH-1:0] srcB;
	logic [`DATA_WIDTH-1:0] writeDataE;
	logic [`DATA_WIDTH-1:0] aluOutE;
	logic sltBit;

	// memory stage wins over writeback
	always_comb begin
		case (forwardAE)
			`FWD_MEM: srcA = aluOutM;
			`FWD_WB: srcA = wbResult;
			default: srcA = decEx.a;
		endcase
	end

	// forwarded b is also the store data
	always_comb begin
		case (forwardBE)
			`FWD_MEM: writeDataE = aluOutM;
			`FWD_WB: writeDataE = wbResult;
			default: writeDataE = decEx.b;
		endcase
	end

	assign srcB = decEx.ctrl.aluSrc ? decEx.signImm : writeDataE;

	// rd for r-type, rt for addi and lw
	assign writeRegE = decEx.ctrl.regDst ? decEx.rd : decEx.rt;
	// seen by the hazard unit for load-use and branch stalls
	assign regWriteE = decEx.ctrl.regWrite;
	assign memToRegE = decEx.ctrl.memToReg;

	// slt is a signed compare
	assign sltBit = ($signed(srcA) < $signed(srcB));

	always_comb begin
		case (decEx.ctrl.aluControl)
			`ALU_AND: aluOutE = srcA & srcB;
			`ALU_OR: aluOutE = srcA | srcB;
			`ALU_ADD: aluOutE = srcA + srcB;
			`ALU_SUB: aluOutE = srcA - srcB;
			`ALU_SLT: aluOutE = {{(`DATA_WIDTH-1){1'b0}}, sltBit};
			default: aluOutE = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exMem <= '0;
		end else begin
			exMem.regWrite <= decEx.ctrl.regWrite;
			exMem.memToReg <= decEx.ctrl.memToReg;
			exMem.memWrite <= decEx.ctrl.memWrite;
			exMem.aluOut <= aluOutE;
			exMem.writeData <= writeDataE;
			exMem.writeReg <= writeRegE;
		end
	end

endmodule

// ==== rtl/memWriteback.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory and writeback stages
// dmem request, memory/writeback register, result mux
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsConsts.svh"

module memWriteback import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input exMemReg exMem,
	input logic [`DATA_WIDTH-1:0] dmemReadData,
	output dmemRequest dmemReq,
	output logic wbRegWrite,
	output logic [`REG_ADDR_WIDTH-1:0] wbWriteReg,
	output logic [`DATA_WIDTH-1:0] wbResult
);

	memWbReg memWb;

	// alu result is the address for lw and sw
	assign dmemReq.addr = exMem.aluOut;
	assign dmemReq.writeData = exMem.writeData;
	// store commits on the next rising edge
	assign dmemReq.write = exMem.memWrite;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memWb <= '0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.readData <= dmemReadData;
			memWb.aluOut <= exMem.aluOut;
			memWb.writeReg <= exMem.writeReg;
		end
	end

	// load data or alu result
	assign wbResult = memWb.memToReg ? memWb.readData : memWb.aluOut;
	assign wbRegWrite = memWb.regWrite;
	assign wbWriteReg = memWb.writeReg;

endmodule

// ==== rtl/hazardControl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline control
// instruction decoder, stalls, flushes and bypass selects
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsConsts.svh"

module hazardControl import mipsPkg::*; (
	input instrWord instrD,
	input logic equalD,
	input logic [`REG_ADDR_WIDTH-1:0] rsE,
	input logic [`REG_ADDR_WIDTH-1:0] rtE,
	input logic regWriteE,
	input logic memToRegE,
	input logic [`REG_ADDR_WIDTH-1:0] writeRegE,
	input exMemReg exMem,
	input logic wbRegWrite,
	input logic [`REG_ADDR_WIDTH-1:0] wbWriteReg,
	output ctrlBundle ctrlD,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE,
	output logic [1:0] pcSel,
	output logic forwardAD,
	output logic forwardBD,
	output logic [1:0] forwardAE,
	output logic [1:0] forwardBE
);

	logic [`REG_ADDR_WIDTH-1:0] rsD;
	logic [`REG_ADDR_WIDTH-1:0] rtD;
	logic lwStall;
	logic branchStall;
	logic stall;
	logic taken;

	// memory stage checked before writeback and r0 never bypassed
	function automatic logic [1:0] fwdSel(input logic [`REG_ADDR_WIDTH-1:0] src);
		if (src != '0 && exMem.regWrite && exMem.writeReg == src) begin
			return `FWD_MEM;
		end
		if (src != '0 && wbRegWrite && wbWriteReg == src) begin
			return `FWD_WB;
		end
		return `FWD_NONE;
	endfunction

	assign rsD = instrD.rForm.rs;
	assign rtD = instrD.rForm.rt;

	// unknown opcodes and functs decode to a nop
	always_comb begin
		ctrlD = '0;
		case (instrD.rForm.opcode)
			`OP_RTYPE: begin
				ctrlD.regDst = 1'b1;
				ctrlD.regWrite = 1'b1;
				case (instrD.rForm.funct)
					`FN_ADD: ctrlD.aluControl = `ALU_ADD;
					`FN_SUB: ctrlD.aluControl = `ALU_SUB;
					`FN_AND: ctrlD.aluControl = `ALU_AND;
					`FN_OR: ctrlD.aluControl = `ALU_OR;
					`FN_SLT: ctrlD.aluControl = `ALU_SLT;
					default: ctrlD.regWrite = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc = 1'b1;
				ctrlD.aluControl = `ALU_ADD;
			end
			`OP_LW: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.memToReg = 1'b1;
				ctrlD.aluSrc = 1'b1;
				ctrlD.aluControl = `ALU_ADD;
			end
			`OP_SW: begin
				ctrlD.memWrite = 1'b1;
				ctrlD.aluSrc = 1'b1;
				ctrlD.aluControl = `ALU_ADD;
			end
			`OP_BEQ: begin
				ctrlD.branch = 1'b1;
				ctrlD.aluControl = `ALU_SUB;
			end
			`OP_J: ctrlD.jump = 1'b1;
			default: ctrlD = '0;
		endcase
	end

	// load in execute feeding the decode instruction
	assign lwStall = memToRegE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD);

	// branch operands not yet ready for the decode compare
	assign branchStall = ctrlD.branch &&
		((regWriteE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
		(exMem.memToReg && exMem.writeReg != '0 &&
		(exMem.writeReg == rsD || exMem.writeReg == rtD)));

	assign stall = lwStall || branchStall;
	assign stallF = stall;
	assign stallD = stall;
	// hold decode and push a bubble into execute
	assign flushE = stall;

	// compare is only trusted once no stall is pending
	assign taken = ctrlD.branch && equalD && !stall;
	assign flushD = taken || (ctrlD.jump && !stall);

	always_comb begin
		if (ctrlD.jump && !stall) begin
			pcSel = `PC_JUMP;
		end else if (taken) begin
			pcSel = `PC_BRANCH;
		end else begin
			pcSel = `PC_SEQ;
		end
	end

	// decode compare only bypasses from the memory stage
	assign forwardAD = rsD != '0 && exMem.regWrite && exMem.writeReg == rsD;
	assign forwardBD = rtD != '0 && exMem.regWrite && exMem.writeReg == rtD;

	// selects follow the memory and writeback stage fields read inside fwdSel
	always_comb begin
		forwardAE = fwdSel(rsE);
		forwardBE = fwdSel(rtE);
	end

endmodule

// ==== rtl/mipsCore.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips core top
// five stages around one control block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsConsts.svh"

module mipsCore import mipsPkg::*; (
	input logic clk,
	input logic arstN,
	input logic [`DATA_WIDTH-1:0] imemInstr,
	input logic [`DATA_WIDTH-1:0] dmemReadData,
	output logic [`DATA_WIDTH-1:0] imemAddr,
	output dmemRequest dmemReq
);

	instrWord instrD;
	logic [`DATA_WIDTH-1:0] pcPlus4D;
	logic [`DATA_WIDTH-1:0] branchTarget;
	logic [`DATA_WIDTH-1:0] jumpTarget;
	ctrlBundle ctrlD;
	decExReg decEx;
	exMemReg exMem;
	logic equalD;
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;
	logic [1:0] pcSel;
	logic forwardAD;
	logic forwardBD;
	logic [1:0] forwardAE;
	logic [1:0] forwardBE;
	logic [`REG_ADDR_WIDTH-1:0] writeRegE;
	logic regWriteE;
	logic memToRegE;
	logic wbRegWrite;
	logic [`REG_ADDR_WIDTH-1:0] wbWriteReg;
	logic [`DATA_WIDTH-1:0] wbResult;

	fetchStage uFetch (
		.clk(clk), .arstN(arstN), .stallF(stallF), .stallD(stallD),
		.flushD(flushD), .pcSel(pcSel), .branchTarget(branchTarget),
		.jumpTarget(jumpTarget), .imemInstr(imemInstr), .imemAddr(imemAddr),
		.instrD(instrD), .pcPlus4D(pcPlus4D)
	);

	// memory stage alu result feeds both bypass paths
	decodeStage uDecode (
		.clk(clk), .arstN(arstN), .instrD(instrD), .pcPlus4D(pcPlus4D),
		.ctrlD(ctrlD), .flushE(flushE), .forwardAD(forwardAD), .forwardBD(forwardBD),
		.aluOutM(exMem.aluOut), .wbRegWrite(wbRegWrite), .wbWriteReg(wbWriteReg),
		.wbResult(wbResult), .equalD(equalD), .branchTarget(branchTarget),
		.jumpTarget(jumpTarget), .decEx(decEx)
	);

	executeStage uExecute (
		.clk(clk), .arstN(arstN), .decEx(decEx), .forwardAE(forwardAE),
		.forwardBE(forwardBE), .aluOutM(exMem.aluOut), .wbResult(wbResult),
		.exMem(exMem), .writeRegE(writeRegE), .regWriteE(regWriteE),
		.memToRegE(memToRegE)
	);

	memWriteback uMemWb (
		.clk(clk), .arstN(arstN), .exMem(exMem), .dmemReadData(dmemReadData),
		.dmemReq(dmemReq), .wbRegWrite(wbRegWrite), .wbWriteReg(wbWriteReg),
		.wbResult(wbResult)
	);

	// execute sources come straight from the decode/execute register
	hazardControl uControl (
		.instrD(instrD), .equalD(equalD), .rsE(decEx.rs), .rtE(decEx.rt),
		.regWriteE(regWriteE), .memToRegE(memToRegE), .writeRegE(writeRegE),
		.exMem(exMem), .wbRegWrite(wbRegWrite), .wbWriteReg(wbWriteReg),
		.ctrlD(ctrlD), .stallF(stallF), .stallD(stallD), .flushD(flushD),
		.flushE(flushE), .pcSel(pcSel), .forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE)
	);

endmodule

// ==== verification/mipsCoreTb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mips core testbench
// assembles a program, models both memories, checks every store
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mipsConsts.svh"

module mipsCoreTb import mipsPkg::*; ();

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} storeT;

	logic clk = 1'b0;
	logic arstN;
	logic [31:0] imemInstr;
	logic [31:0] dmemReadData;
	logic [31:0] imemAddr;
	dmemRequest dmemReq;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	// reference copies, updated by the assembler as it emits code
	logic [31:0] refMem [0:255];
	logic [31:0] refRegs [0:31];
	storeT expQ [$];
	logic [15:0] lfsrState;
	int pcIdx;
	int storeOff;
	int cycles = 0;
	int limit;
	int valueErrors = 0;
	int missingErrors = 0;
	int otherErrors = 0;

	mipsCore UUT (
		.clk(clk), .arstN(arstN), .imemInstr(imemInstr), .dmemReadData(dmemReadData),
		.imemAddr(imemAddr), .dmemReq(dmemReq)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	// both memories answer in the same cycle
	assign imemInstr = arstN ? imem[imemAddr[9:2]] : '0;
	assign dmemReadData = arstN ? dmem[dmemReq.addr[9:2]] : '0;

	// store commits on the rising edge
	always @(posedge clk) begin
		if (arstN && dmemReq.write) begin
			dmem[dmemReq.addr[9:2]] <= dmemReq.writeData;
		end
	end

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return v;
	endfunction

	function automatic logic [31:0] signExtend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[8'(pcIdx)] = word;
		pcIdx++;
	endtask

	task automatic addImm(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		emit({`OP_ADDI, rs, rt, imm});
		if (rt != 5'd0) begin
			refRegs[rt] = refRegs[rs] + signExtend(imm);
		end
	endtask

	// r-type result straight from the instruction set definition
	task automatic regOp(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		a = refRegs[rs];
		b = refRegs[rt];
		case (fn)
			`FN_ADD: r = a + b;
			`FN_SUB: r = a - b;
			`FN_AND: r = a & b;
			`FN_OR: r = a | b;
			`FN_SLT: r = {31'b0, ($signed(a) < $signed(b))};
			default: r = '0;
		endcase
		emit({`OP_RTYPE, rs, rt, rd, 5'd0, fn});
		if (rd != 5'd0) begin
			refRegs[rd] = r;
		end
	endtask

	// every store goes to its own word above the base in r1
	task automatic storeWord(input logic [4:0] rt, input bit expected);
		storeT e;
		e.addr = refRegs[1] + signExtend(16'(storeOff));
		e.data = refRegs[rt];
		emit({`OP_SW, 5'd1, rt, 16'(storeOff)});
		storeOff += 4;
		if (expected) begin
			expQ.push_back(e);
			refMem[e.addr[9:2]] = e.data;
		end
	endtask

	task automatic loadWord(input logic [4:0] rt, input logic [15:0] imm);
		logic [31:0] addr;
		addr = signExtend(imm);
		emit({`OP_LW, 5'd0, rt, imm});
		refRegs[rt] = refMem[addr[9:2]];
	endtask

	// offset of one skips the next word when taken
	task automatic branchEq(input logic [4:0] rs, input logic [4:0] rt, output bit taken);
		taken = (refRegs[rs] == refRegs[rt]);
		emit({`OP_BEQ, rs, rt, 16'd1});
	endtask

	task automatic buildProgram();
		logic [31:0] loadVal;
		bit taken;
		addImm(5'd1, 5'd0, 16'h0100);
		// random operands, every op stored right behind it
		for (int round = 0; round < 3; round++) begin
			addImm(5'd2, 5'd0, 16'(randomBits(16)));
			addImm(5'd3, 5'd0, 16'(randomBits(16)));
			storeWord(5'd2, 1'b1);
			regOp(`FN_ADD, 5'd4, 5'd2, 5'd3);
			storeWord(5'd4, 1'b1);
			regOp(`FN_SUB, 5'd5, 5'd2, 5'd3);
			storeWord(5'd5, 1'b1);
			regOp(`FN_AND, 5'd6, 5'd2, 5'd3);
			storeWord(5'd6, 1'b1);
			regOp(`FN_OR, 5'd7, 5'd2, 5'd3);
			storeWord(5'd7, 1'b1);
			regOp(`FN_SLT, 5'd8, 5'd2, 5'd3);
			storeWord(5'd8, 1'b1);
		end
		// dependent chain, no nops between
		regOp(`FN_ADD, 5'd9, 5'd4, 5'd5);
		regOp(`FN_ADD, 5'd10, 5'd9, 5'd4);
		regOp(`FN_SUB, 5'd15, 5'd10, 5'd9);
		storeWord(5'd15, 1'b1);
		// load-use pair on a preloaded word
		loadVal = randomBits(32);
		dmem[32] = loadVal;
		refMem[32] = loadVal;
		loadWord(5'd11, 16'h0080);
		regOp(`FN_ADD, 5'd12, 5'd11, 5'd3);
		storeWord(5'd12, 1'b1);
		// taken beq
		addImm(5'd13, 5'd0, 16'd5);
		addImm(5'd14, 5'd0, 16'd5);
		branchEq(5'd13, 5'd14, taken);
		storeWord(5'd13, !taken);
		storeWord(5'd14, 1'b1);
		// falls through unless r2 happens to hold 5
		branchEq(5'd13, 5'd2, taken);
		storeWord(5'd2, !taken);
		emit({`OP_J, 26'(pcIdx + 2)});
		storeWord(5'd3, 1'b0);
		storeWord(5'd4, 1'b1);
		// park on a jump to itself
		emit({`OP_J, 26'(pcIdx)});
	endtask

	// outputs sampled mid-cycle, away from the register updates
	always @(negedge clk) begin
		storeT head;
		if (!arstN) begin
			assert (imemAddr == '0) else begin
				valueErrors++;
				$display("ERROR: imemAddr got %h expected %h during reset", imemAddr, 32'h0);
			end
			assert (!dmemReq.write) else begin
				otherErrors++;
				$display("a store request appeared while reset was held");
			end
		end else if (dmemReq.write) begin
			if (expQ.size() == 0) begin
				otherErrors++;
				$display("store to address %h arrived when no store was expected", dmemReq.addr);
			end else begin
				head = expQ.pop_front();
				assert (dmemReq.addr == head.addr) else begin
					valueErrors++;
					$display("ERROR: dmemReq.addr got %h expected %h", dmemReq.addr, head.addr);
				end
				assert (dmemReq.writeData == head.data) else begin
					valueErrors++;
					$display("ERROR: dmemReq.writeData got %h expected %h",
						dmemReq.writeData, head.data);
				end
			end
		end
	end

	initial begin
		arstN = 1'b0;
		lfsrState = 16'd45;
		pcIdx = 0;
		storeOff = 0;
		// nops in imem, address-dependent words in dmem
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = (32'(i) * 32'h9E3779B1) ^ {24'(i), 8'h5A};
			refMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		buildProgram();
		limit = 4 * pcIdx + 40;
		repeat (8) @(negedge clk);
		arstN <= 1'b1;
		while (expQ.size() != 0 && cycles < limit) begin
			@(negedge clk);
		end
		if (expQ.size() != 0) begin
			missingErrors += expQ.size();
			$display("cycle limit %0d reached with %0d expected stores never seen",
				limit, expQ.size());
		end else begin
			// a few more cycles to catch stray stores
			repeat (10) @(negedge clk);
		end
		$display("errors: value %0d, missing %0d, other %0d",
			valueErrors, missingErrors, otherErrors);
		if (valueErrors + missingErrors + otherErrors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== mipsCore.f ====
+incdir+rtl
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWriteback.sv
rtl/hazardControl.sv
rtl/mipsCore.sv
verification/mipsCoreTb.sv

// ==== Makefile ====
# Verilator flow for the mips core testbench

VERILATOR ?= verilator
TOP ?= mipsCoreTb
FILELIST ?= mipsCore.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= STATUS: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
